/* design/spi3w_defs.svh */
`ifndef SPI3W_DEFS_SVH
`define SPI3W_DEFS_SVH

// ******************************
// Widths of the SPI master
// ******************************

// Baud divider, one half-bit lasts baud+1 clocks
`define SPI_BAUD_W 8

// Prescaler and timeout counters, loaded by word writes
`define SPI_TIMER_W 16

// Half-bit counter, 15 down to 0 for one byte
`define SPI_BIT_CNT_W 4

// Flops in the GPIO input synchronizer
`define SPI_GPIO_SYNC 3

`endif

/* design/spiRegPkg.sv */
package spiRegPkg;

  // Byte addresses
  localparam logic [1:0] addrCtrl = 2'd0;
  localparam logic [1:0] addrBaud = 2'd1;
  localparam logic [1:0] addrData = 2'd2;
  localparam logic [1:0] addrGpio = 2'd3;

  // Word addresses
  localparam logic [1:0] addrPres = 2'd2;
  localparam logic [1:0] addrTout = 2'd3;

  // Access size on the enable lines, 10 is not a legal code
  typedef enum logic [1:0] {
    NONE = 2'b00,
    BYTE = 2'b01,
    WORD = 2'b11
  } accessSizeE;

  // Control byte as written
  typedef struct packed {
    logic       wrRd;
    logic       msbLsb;
    logic [1:0] mode;
    logic [3:0] outEn;
  } ctrlWrT;

  // Control byte as read back, flags replace the top two bits
  typedef struct packed {
    logic       busy;
    logic       timerNZ;
    logic [1:0] mode;
    logic [3:0] outEn;
  } ctrlRdT;

  typedef union packed {
    ctrlWrT ctrlWr;
    ctrlRdT ctrlRd;
  } ctrlRegU;

endpackage

/* design/spiCorePkg.sv */
package spiCorePkg;

`include "spi3w_defs.svh"

  // Bit 1 is the idle clock level
  typedef enum logic [1:0] {
    MODE0 = 2'd0,
    MODE1 = 2'd1,
    MODE2 = 2'd2,
    MODE3 = 2'd3
  } spiModeE;

  typedef enum logic {
    LSB_FIRST = 1'b0,
    MSB_FIRST = 1'b1
  } bitOrderE;

  typedef logic [`SPI_BIT_CNT_W-1:0] bitCntT;
  typedef logic [`SPI_BAUD_W-1:0] baudCntT;

endpackage

/* design/spiCfgIf.sv */
`timescale 1ns/100ps
`include "spi3w_defs.svh"

interface spiCfgIf;
  import spiCorePkg::*;

  // Shift engine configuration
  logic       wrRd;
  bitOrderE   msbLsb;
  spiModeE    mode;
  logic [3:0] outEn;
  baudCntT    baud;
  logic       dataWr;
  logic [7:0] txByte;

  // Timer configuration
  logic [`SPI_TIMER_W-1:0] presCfg;
  logic [`SPI_TIMER_W-1:0] toutCfg;
  logic                    timerRestart;

  modport decode (output wrRd, msbLsb, mode, outEn, baud, dataWr, txByte,
                  output presCfg, toutCfg, timerRestart);
  modport engine (input wrRd, msbLsb, mode, outEn, baud, dataWr, txByte);
  modport timer  (input presCfg, toutCfg, timerRestart);

endinterface

/* design/spiRegDecode.sv */
`timescale 1ns/100ps
`include "spi3w_defs.svh"

module spiRegDecode
(
  input  logic                  AClkH,
  input  logic                  AResetB,
  input  logic [1:0]            addr,
  input  logic [15:0]           mosi,
  input  spiRegPkg::accessSizeE wrEn,
  input  spiRegPkg::accessSizeE rdEn,
  input  logic                  gpioInRaw,
  spiCfgIf.decode               cfg,
  output spiRegPkg::ctrlRegU    ctrlCfg,
  output logic [1:0]            gpioOut,
  output logic                  gpioIn
);
  import spiRegPkg::*;
  import spiCorePkg::*;

  logic                      byteWr;
  logic                      wordWr;
  logic                      wordRd;
  ctrlRegU                   ctrlReg;
  logic [`SPI_BAUD_W-1:0]    baudReg;
  logic [1:0]                gpioOutReg;
  logic [`SPI_TIMER_W-1:0]   presReg;
  logic [`SPI_TIMER_W-1:0]   toutReg;
  logic [`SPI_GPIO_SYNC-1:0] gpioSync;

  assign byteWr = (wrEn == BYTE);
  assign wordWr = (wrEn == WORD);
  assign wordRd = (rdEn == WORD);

  // ******************************
  // Configuration registers
  // ******************************
  always_ff @(posedge AClkH or negedge AResetB)
  begin
    if (!AResetB)
    begin
      ctrlReg    <= '0;
      baudReg    <= '0;
      gpioOutReg <= '0;
      presReg    <= '0;
      toutReg    <= '0;
      gpioSync   <= '0;
    end
    else
    begin
      if (byteWr && addr == addrCtrl)
        ctrlReg <= mosi[7:0];
      if (byteWr && addr == addrBaud)
        baudReg <= mosi[`SPI_BAUD_W-1:0];
      if (byteWr && addr == addrGpio)
        gpioOutReg <= mosi[1:0];
      if (wordWr && addr == addrPres)
        presReg <= mosi[`SPI_TIMER_W-1:0];
      if (wordWr && addr == addrTout)
        toutReg <= mosi[`SPI_TIMER_W-1:0];
      // Pin sampled into the first stage
      gpioSync <= {gpioSync[`SPI_GPIO_SYNC-2:0], gpioInRaw};
    end
  end

  // Engine side
  assign cfg.wrRd   = ctrlReg.ctrlWr.wrRd;
  assign cfg.msbLsb = bitOrderE'(ctrlReg.ctrlWr.msbLsb);
  assign cfg.mode   = spiModeE'(ctrlReg.ctrlWr.mode);
  assign cfg.outEn  = ctrlReg.ctrlWr.outEn;
  assign cfg.baud   = baudReg;
  assign cfg.dataWr = byteWr && (addr == addrData);
  assign cfg.txByte = mosi[7:0];

  // Timer side, reading the timeout word restarts it
  assign cfg.presCfg      = presReg;
  assign cfg.toutCfg      = toutReg;
  assign cfg.timerRestart = wordRd && (addr == addrTout);

  assign ctrlCfg = ctrlReg;
  assign gpioOut = gpioOutReg;
  assign gpioIn  = gpioSync[`SPI_GPIO_SYNC-1];

  enCodeLegal: assert property (@(posedge AClkH) disable iff (!AResetB)
    (wrEn != 2'b10) && (rdEn != 2'b10));

endmodule

/* design/spiShiftEngine.sv */
`timescale 1ns/100ps
`include "spi3w_defs.svh"

module spiShiftEngine
(
  input  logic       AClkH,
  input  logic       AResetB,
  spiCfgIf.engine    cfg,
  input  logic       spiMiso,
  output logic       spiSck,
  output logic       spiMosi,
  output logic [3:0] spiOutEn,
  output logic       busy,
  output logic [7:0] rxByte
);
  import spiCorePkg::*;

  baudCntT    baudDiv;
  baudCntT    baudDivNext;
  bitCntT     bitCnt;
  bitCntT     bitCntNext;
  logic [7:0] shiftOut;
  logic [7:0] shiftIn;
  logic [7:0] txRev;
  logic [7:0] txOrdered;
  logic [1:0] modeBits;
  logic       sck;
  logic       sckNext;
  logic       misoReg;
  logic       divNZ;
  logic       cntNZ;
  logic       halfEnd;
  logic       shiftEn;
  logic       sampleEn;

  assign modeBits = cfg.mode;
  assign divNZ    = |baudDiv;
  assign cntNZ    = |bitCnt;

  // Half-bit ends when the divider runs out
  assign halfEnd  = busy & ~divNZ;
  assign sampleEn = halfEnd & bitCnt[0];
  assign shiftEn  = halfEnd & ~bitCnt[0];

  // Shifter always sends bit 7, so LSB-first data goes in reversed
  assign txRev     = {<<{cfg.txByte}};
  assign txOrdered = (cfg.msbLsb == MSB_FIRST) ? cfg.txByte : txRev;

  // ******************************
  // Divider and half-bit counter
  // ******************************
  always_comb
  begin
    if (cfg.dataWr)
    begin
      baudDivNext = cfg.baud;
      bitCntNext  = '1;
      sckNext     = modeBits[1] ^ modeBits[0];
    end
    else
    begin
      if (divNZ)
        baudDivNext = baudDiv - baudCntT'(1);
      else
        baudDivNext = cntNZ ? cfg.baud : '0;
      bitCntNext = bitCnt - bitCntT'(~divNZ & cntNZ);
      // Toggle at each half-bit end, rest at the idle level
      sckNext = busy ? (sck ^ ~divNZ) : modeBits[1];
    end
  end

  always_ff @(posedge AClkH or negedge AResetB)
  begin
    if (!AResetB)
    begin
      baudDiv  <= '0;
      bitCnt   <= '0;
      busy     <= 1'b0;
      sck      <= 1'b0;
      misoReg  <= 1'b0;
      shiftOut <= '0;
      shiftIn  <= '0;
    end
    else
    begin
      baudDiv <= baudDivNext;
      bitCnt  <= bitCntNext;
      busy    <= (|bitCntNext) | (|baudDivNext);
      sck     <= sckNext;
      misoReg <= spiMiso;
      if (cfg.dataWr)
        shiftOut <= txOrdered;
      else if (shiftEn)
        shiftOut <= {shiftOut[6:0], 1'b0};
      if (sampleEn)
      begin
        if (cfg.msbLsb == MSB_FIRST)
          shiftIn <= {shiftIn[6:0], misoReg};
        else
          shiftIn <= {misoReg, shiftIn[7:1]};
      end
    end
  end

  assign spiSck  = sck;
  assign spiMosi = shiftOut[7];
  assign rxByte  = shiftIn;

  // MOSI driver enabled only while sending
  assign spiOutEn = {cfg.outEn[3], cfg.outEn[2] & busy & cfg.wrRd, cfg.outEn[1:0]};

  // Idle engine keeps its counter at zero until the next data write
  idleCntZero: assert property (@(posedge AClkH) disable iff (!AResetB)
    (!busy && !cfg.dataWr) |=> (bitCnt == '0 && !busy));

endmodule

/* design/spiTimer.sv */
`timescale 1ns/100ps
`include "spi3w_defs.svh"

module spiTimer
(
  input  logic    AClkH,
  input  logic    AResetB,
  spiCfgIf.timer  cfg,
  output logic    timerNZ
);
  localparam logic [`SPI_TIMER_W-1:0] timerOne = 1;

  logic [`SPI_TIMER_W-1:0] pres;
  logic [`SPI_TIMER_W-1:0] presNext;
  logic [`SPI_TIMER_W-1:0] tout;
  logic [`SPI_TIMER_W-1:0] toutNext;
  logic                    presNZ;
  logic                    toutNZ;

  assign presNZ = |pres;
  assign toutNZ = |tout;

  always_comb
  begin
    if (cfg.timerRestart)
    begin
      presNext = cfg.presCfg;
      toutNext = cfg.toutCfg;
    end
    else
    begin
      // Prescaler wraps back to its reload while time is left
      if (presNZ)
        presNext = pres - timerOne;
      else
        presNext = toutNZ ? cfg.presCfg : '0;
      toutNext = (toutNZ && !presNZ) ? tout - timerOne : tout;
    end
  end

  always_ff @(posedge AClkH or negedge AResetB)
  begin
    if (!AResetB)
    begin
      pres    <= '0;
      tout    <= '0;
      timerNZ <= 1'b0;
    end
    else
    begin
      pres    <= presNext;
      tout    <= toutNext;
      timerNZ <= (|presNext) | (|toutNext);
    end
  end

  // Flag drops only after the timeout ran out, on a zero reload or a restart
  nzFallsAtZero: assert property (@(posedge AClkH) disable iff (!AResetB)
    $fell(timerNZ) |-> $past(tout == '0 || cfg.presCfg == '0 || cfg.timerRestart));

endmodule

/* design/spiReadMux.sv */
`timescale 1ns/100ps
`include "spi3w_defs.svh"

module spiReadMux
(
  input  logic [1:0]             addr,
  input  spiRegPkg::accessSizeE  rdEn,
  input  spiRegPkg::ctrlRegU     ctrlCfg,
  input  logic                   busy,
  input  logic                   timerNZ,
  input  logic [`SPI_BAUD_W-1:0] baud,
  input  logic [7:0]             rxByte,
  input  logic [1:0]             gpioOut,
  input  logic                   gpioIn,
  output logic [7:0]             miso
);
  import spiRegPkg::*;

  ctrlRegU ctrlView;

  always_comb
  begin
    // Live flags over the written direction and order bits
    ctrlView = ctrlCfg;
    ctrlView.ctrlRd.busy = busy;
    ctrlView.ctrlRd.timerNZ = timerNZ;
    miso = '0;
    if (rdEn == BYTE)
    begin
      case (addr)
        addrCtrl: miso = ctrlView;
        addrBaud: miso = baud;
        addrData: miso = rxByte;
        default:  miso = {3'b000, gpioIn, 2'b00, gpioOut};
      endcase
    end
  end

endmodule

/* design/spi3wTop.sv */
`timescale 1ns/100ps
`include "spi3w_defs.svh"

module spi3wTop
(
  input  logic                  AClkH,
  input  logic                  AResetB,
  input  logic [1:0]            AAddr,
  input  logic [15:0]           AMosi,
  output logic [7:0]            AMiso,
  input  spiRegPkg::accessSizeE AWrEn,
  input  spiRegPkg::accessSizeE ARdEn,
  output logic                  ASpiSck,
  input  logic                  ASpiMiso,
  output logic                  ASpiMosi,
  input  logic                  ASpiGpioI,
  output logic [1:0]            ASpiGpioO,
  output logic [3:0]            ASpiOutEn
);
  import spiRegPkg::*;

  ctrlRegU    ctrlCfg;
  logic       busy;
  logic       timerNZ;
  logic [7:0] rxByte;
  logic       gpioIn;

  spiCfgIf cfgIf ();

  // ******************************
  // Register side
  // ******************************
  spiRegDecode uDecode
  (
    .AClkH     (AClkH),
    .AResetB   (AResetB),
    .addr      (AAddr),
    .mosi      (AMosi),
    .wrEn      (AWrEn),
    .rdEn      (ARdEn),
    .gpioInRaw (ASpiGpioI),
    .cfg       (cfgIf.decode),
    .ctrlCfg   (ctrlCfg),
    .gpioOut   (ASpiGpioO),
    .gpioIn    (gpioIn)
  );

  spiReadMux uReadMux
  (
    .addr    (AAddr),
    .rdEn    (ARdEn),
    .ctrlCfg (ctrlCfg),
    .busy    (busy),
    .timerNZ (timerNZ),
    .baud    (cfgIf.baud),
    .rxByte  (rxByte),
    .gpioOut (ASpiGpioO),
    .gpioIn  (gpioIn),
    .miso    (AMiso)
  );

  // ******************************
  // SPI engine and timer
  // ******************************
  spiShiftEngine uEngine
  (
    .AClkH    (AClkH),
    .AResetB  (AResetB),
    .cfg      (cfgIf.engine),
    .spiMiso  (ASpiMiso),
    .spiSck   (ASpiSck),
    .spiMosi  (ASpiMosi),
    .spiOutEn (ASpiOutEn),
    .busy     (busy),
    .rxByte   (rxByte)
  );

  spiTimer uTimer
  (
    .AClkH   (AClkH),
    .AResetB (AResetB),
    .cfg     (cfgIf.timer),
    .timerNZ (timerNZ)
  );

endmodule

/* tb/spiClockGen.sv */
`timescale 1ns/100ps

module spiClockGen
#(
  parameter int unsigned period      = 40,
  parameter int unsigned resetCycles = 5
)
(
  output logic AClkH,
  output logic AResetB
);

  initial
  begin
    AClkH = 1'b0;
    forever
      #(period / 2) AClkH = ~AClkH;
  end

  // Reset held for a few clocks, released on a falling edge
  initial
  begin
    AResetB = 1'b0;
    repeat (resetCycles) @(posedge AClkH);
    @(negedge AClkH);
    AResetB = 1'b1;
  end

endmodule

/* tb/spi3wTb.sv */
`timescale 1ns/100ps
`include "spi3w_defs.svh"

module spi3wTb;
  import spiRegPkg::*;
  import spiCorePkg::*;

  localparam int unsigned clkPeriod    = 40;
  localparam logic [31:0] seed         = 32'h54ad_e757;
  localparam int unsigned repsPerCombo = 2;
  localparam int unsigned numTransfers = 8 * repsPerCombo;
  localparam int unsigned timerMax     = 15;
  localparam int unsigned timerRuns    = 2;
  localparam int unsigned watchdogCycles = numTransfers * 16 * (2 ** `SPI_BAUD_W)
    + timerRuns * ((timerMax + 1) * (timerMax + 1) + 2) + 2000;

  logic       AClkH;
  logic       AResetB;
  logic [1:0] AAddr;
  logic [15:0] AMosi;
  logic [7:0] AMiso;
  accessSizeE AWrEn;
  accessSizeE ARdEn;
  logic       ASpiSck;
  logic       ASpiMiso;
  logic       ASpiMosi;
  logic       ASpiGpioI;
  logic [1:0] ASpiGpioO;
  logic [3:0] ASpiOutEn;

  // Register model behind the reference function
  logic [7:0] ctrlModel;
  logic [7:0] baudModel;
  logic [7:0] rxModel;
  logic [1:0] gpioOutModel;
  logic       gpioInModel;
  logic       busyModel;
  logic       tnzModel;

  // Hand-off from the bus tasks to the compare process
  string       testName;
  logic [1:0]  readAddr;
  logic [7:0]  readData;
  logic        readChecked;
  int unsigned issuedCount;
  int unsigned seenCount;
  int unsigned cycleCnt = 0;
  event        readDone;

  spiClockGen #(.period(clkPeriod), .resetCycles(5)) clkGen0
  (
    .AClkH   (AClkH),
    .AResetB (AResetB)
  );

  spi3wTop dut0
  (
    .AClkH     (AClkH),
    .AResetB   (AResetB),
    .AAddr     (AAddr),
    .AMosi     (AMosi),
    .AMiso     (AMiso),
    .AWrEn     (AWrEn),
    .ARdEn     (ARdEn),
    .ASpiSck   (ASpiSck),
    .ASpiMiso  (ASpiMiso),
    .ASpiMosi  (ASpiMosi),
    .ASpiGpioI (ASpiGpioI),
    .ASpiGpioO (ASpiGpioO),
    .ASpiOutEn (ASpiOutEn)
  );

  // Slave side simply echoes MOSI
  assign ASpiMiso = ASpiMosi;

  always @(posedge AClkH)
    cycleCnt <= cycleCnt + 1;

  // ******************************
  // Reference and compare tasks
  // ******************************
  function automatic logic [7:0] expectRead(input logic [1:0] addr);
    logic [7:0] value;
    case (addr)
      addrCtrl: value = {busyModel, tnzModel, ctrlModel[5:0]};
      addrBaud: value = baudModel;
      addrData: value = rxModel;
      default:  value = {3'b000, gpioInModel, 2'b00, gpioOutModel};
    endcase
    return value;
  endfunction

  task automatic stopOnFailure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic checkByte(input string name, input logic [7:0] expVal,
                           input logic [7:0] actVal);
    if (actVal !== expVal)
      stopOnFailure($sformatf("FAIL %s expected %02h actual %02h", name, expVal, actVal));
  endtask

  task automatic checkCtrl(input string name, input ctrlRegU expVal, input ctrlRegU actVal);
    if (actVal !== expVal)
      stopOnFailure($sformatf("FAIL %s expected %02h actual %02h (busy %0b/%0b nz %0b/%0b)",
        name, expVal, actVal, expVal.ctrlRd.busy, actVal.ctrlRd.busy,
        expVal.ctrlRd.timerNZ, actVal.ctrlRd.timerNZ));
  endtask

  task automatic checkLevel(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal)
      stopOnFailure($sformatf("FAIL %s expected %0b actual %0b", name, expVal, actVal));
  endtask

  always @(readDone)
  begin : compareReads
    ctrlRegU expCtrl;
    ctrlRegU actCtrl;
    if (readChecked)
    begin
      if (readAddr == addrCtrl)
      begin
        expCtrl = expectRead(readAddr);
        actCtrl = readData;
        checkCtrl(testName, expCtrl, actCtrl);
      end
      else
        checkByte($sformatf("%s addr %0d", testName, readAddr), expectRead(readAddr), readData);
    end
    seenCount++;
  end

  // ******************************
  // Bus tasks
  // ******************************
  // Each one starts and ends on a falling edge
  task automatic writeByte(input logic [1:0] addr, input logic [7:0] data);
    AAddr = addr;
    AMosi = {8'h00, data};
    AWrEn = BYTE;
    @(negedge AClkH);
    AWrEn = NONE;
  endtask

  task automatic writeWord(input logic [1:0] addr, input logic [15:0] data);
    AAddr = addr;
    AMosi = data;
    AWrEn = WORD;
    @(negedge AClkH);
    AWrEn = NONE;
  endtask

  task automatic readByte(input logic [1:0] addr, input logic checked,
                          output logic [7:0] data);
    AAddr = addr;
    ARdEn = BYTE;
    #(clkPeriod / 4);
    data        = AMiso;
    readAddr    = addr;
    readData    = AMiso;
    readChecked = checked;
    issuedCount++;
    ->readDone;
    @(negedge AClkH);
    ARdEn = NONE;
  endtask

  // Word reads carry no data back
  task automatic readWord(input logic [1:0] addr);
    AAddr = addr;
    ARdEn = WORD;
    #(clkPeriod / 4);
    checkByte($sformatf("%s word read", testName), 8'h00, AMiso);
    @(negedge AClkH);
    ARdEn = NONE;
  endtask

  task automatic waitCycles(input int unsigned n);
    repeat (n) @(negedge AClkH);
  endtask

  // ******************************
  // Tests
  // ******************************
  task automatic resetTest();
    logic [7:0] data;
    testName = "after reset";
    for (int a = 0; a < 4; a++)
      readByte(2'(a), 1'b1, data);
    checkLevel("reset sck", 1'b0, ASpiSck);
    checkLevel("reset mosi", 1'b0, ASpiMosi);
    checkByte("reset enables", 8'h00, {4'b0000, ASpiOutEn});
    checkByte("reset gpio out", 8'h00, {6'b000000, ASpiGpioO});
  endtask

  task automatic regReadbackTest();
    logic [7:0] data;
    logic [7:0] gpioByte;
    testName = "register readback";
    repeat (8)
    begin
      ctrlModel = 8'($urandom);
      baudModel = 8'($urandom);
      gpioByte  = 8'($urandom);
      writeByte(addrCtrl, ctrlModel);
      writeByte(addrBaud, baudModel);
      writeByte(addrGpio, gpioByte);
      gpioOutModel = gpioByte[1:0];
      for (int a = 0; a < 4; a++)
        readByte(2'(a), 1'b1, data);
      checkByte("gpio pins", {6'b000000, gpioOutModel}, {6'b000000, ASpiGpioO});
      // MOSI enable stays off while idle
      checkByte("idle enables", {4'b0000, ctrlModel[3:0] & 4'b1011}, {4'b0000, ASpiOutEn});
    end
  endtask

  task automatic loopbackTest();
    logic [7:0] data;
    logic [7:0] txByte;
    logic [3:0] outEnBits;
    logic [1:0] modeBits;
    logic       wrRdBit;
    logic       busyFlag;
    spiModeE    modeSel;
    bitOrderE   orderSel;
    for (int m = 0; m < 4; m++)
      for (int o = 0; o < 2; o++)
        repeat (repsPerCombo)
        begin
          modeSel   = spiModeE'(m);
          orderSel  = bitOrderE'(o);
          modeBits  = modeSel;
          wrRdBit   = 1'($urandom);
          outEnBits = 4'($urandom);
          txByte    = 8'($urandom);
          testName  = $sformatf("loopback mode %0d order %0d", m, o);
          ctrlModel = {wrRdBit, orderSel, modeSel, outEnBits};
          baudModel = 8'(($urandom % 7) + 1);
          writeByte(addrCtrl, ctrlModel);
          writeByte(addrBaud, baudModel);
          writeByte(addrData, txByte);
          busyModel = 1'b1;
          readByte(addrCtrl, 1'b1, data);
          checkLevel($sformatf("%s busy enable", testName), outEnBits[2] & wrRdBit,
                     ASpiOutEn[2]);
          busyFlag = 1'b1;
          while (busyFlag)
          begin
            readByte(addrCtrl, 1'b0, data);
            busyFlag = data[7];
          end
          busyModel = 1'b0;
          rxModel   = txByte;
          readByte(addrData, 1'b1, data);
          checkLevel($sformatf("%s idle sck", testName), modeBits[1], ASpiSck);
          checkLevel($sformatf("%s idle enable", testName), 1'b0, ASpiOutEn[2]);
          readByte(addrCtrl, 1'b1, data);
        end
  endtask

  task automatic gpioInTest();
    logic [7:0] data;
    logic       pinBit;
    testName = "gpio input";
    repeat (4)
    begin
      pinBit    = 1'($urandom);
      ASpiGpioI = pinBit;
      waitCycles(4);
      gpioInModel = pinBit;
      readByte(addrGpio, 1'b1, data);
    end
  endtask

  task automatic timerTest();
    logic [7:0]  data;
    logic        nzFlag;
    int unsigned presVal;
    int unsigned toutVal;
    int unsigned bound;
    int unsigned startCycle;
    presVal  = ($urandom % timerMax) + 1;
    toutVal  = ($urandom % timerMax) + 1;
    bound    = (toutVal + 1) * (presVal + 1) + 2;
    testName = $sformatf("timer pres %0d tout %0d", presVal, toutVal);
    writeWord(addrPres, 16'(presVal));
    writeWord(addrTout, 16'(toutVal));
    readWord(addrTout);
    startCycle = cycleCnt;
    tnzModel   = 1'b1;
    readByte(addrCtrl, 1'b1, data);
    nzFlag = 1'b1;
    while (nzFlag && (cycleCnt - startCycle) <= bound)
    begin
      readByte(addrCtrl, 1'b0, data);
      nzFlag = data[6];
    end
    if (nzFlag)
      stopOnFailure($sformatf("Timer flag still set %0d cycles after restart", bound));
    else
    begin
      tnzModel = 1'b0;
      readByte(addrCtrl, 1'b1, data);
    end
  endtask

  // ******************************
  // Main sequence and watchdog
  // ******************************
  initial
  begin
    AAddr        = '0;
    AMosi        = '0;
    AWrEn        = NONE;
    ARdEn        = NONE;
    ASpiGpioI    = 1'b0;
    ctrlModel    = '0;
    baudModel    = '0;
    rxModel      = '0;
    gpioOutModel = '0;
    gpioInModel  = 1'b0;
    busyModel    = 1'b0;
    tnzModel     = 1'b0;
    readChecked  = 1'b0;
    issuedCount  = 0;
    seenCount    = 0;
    testName     = "idle";
    void'($urandom(seed));
    wait (AResetB === 1'b1);
    @(negedge AClkH);
    resetTest();
    regReadbackTest();
    loopbackTest();
    gpioInTest();
    repeat (timerRuns) timerTest();
    waitCycles(2);
    if (seenCount == issuedCount)
    begin
      $display("TESTS PASSED");
      $finish;
    end
    else
      stopOnFailure("The compare process did not see every read");
  end

  initial
  begin
    repeat (watchdogCycles) @(posedge AClkH);
    stopOnFailure($sformatf("Watchdog expired after %0d cycles, tests did not finish",
      watchdogCycles));
  end

endmodule

/* spi3w.f */
+incdir+design
design/spiRegPkg.sv
design/spiCorePkg.sv
design/spiCfgIf.sv
design/spiRegDecode.sv
design/spiShiftEngine.sv
design/spiTimer.sv
design/spiReadMux.sv
design/spi3wTop.sv
tb/spiClockGen.sv
tb/spi3wTb.sv

/* Makefile */
SIM = obj_dir/Vspi3wTb

.PHONY: compile run clean

compile:
	verilator --binary --assert --timescale 1ns/100ps -f spi3w.f --top spi3wTb

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
